// ==== mem_bridge_pkg.sv ====
package mem_bridge_pkg;

    //////////////////////////////
    // Basic widths
    //////////////////////////////
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [31:0] word_t;    // One bus word
    typedef logic [3:0]  strb_t;    // Byte lane mask

    //////////////////////////////
    // AXI field types
    //////////////////////////////
    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;  // Beats minus one
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;

    // Ids split the read data return
    localparam axi_id_t INST_ID = 4'd0;  // Instruction line refill
    localparam axi_id_t DATA_ID = 4'd1;  // Data reads and writes

    localparam axi_size_t  AXI_SIZE_WORD  = 3'd2;  // 4 bytes per beat
    localparam axi_burst_t AXI_BURST_INCR = 2'd1;

    // Execution lanes feeding the data port
    localparam int NUM_LANES = 2;

endpackage

// ==== dcache_port.sv ====
module dcache_port
    import mem_bridge_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,

    // Lanes
    input  logic  [NUM_LANES-1:0]   lane_ce_i,
    input  logic  [NUM_LANES-1:0]   lane_we_i,
    input  addr_t [NUM_LANES-1:0]   lane_addr_i,
    input  word_t [NUM_LANES-1:0]   lane_wdata_i,
    input  strb_t [NUM_LANES-1:0]   lane_wstrb_i,
    output logic                    dcache_ready_o,
    output logic                    data_ok_o,
    output word_t                   rdata_o,

    // Read master side
    output logic                    rd_req_o,
    output addr_t                   rd_addr_o,
    input  logic                    rd_rdy_i,
    input  logic                    ret_valid_i,
    input  word_t                   ret_data_i,

    // Write master side
    output logic                    wr_req_o,
    output addr_t                   wr_addr_o,
    output word_t                   wr_data_o,
    output strb_t                   wr_strb_o,
    input  logic                    wr_rdy_i,
    input  logic                    wr_done_i
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_DONE} state_t;

    state_t state;
    logic   any_ce;
    logic   sel_we;
    addr_t  sel_addr;
    word_t  sel_wdata;
    strb_t  sel_wstrb;

    // Held request
    logic   req_we;
    addr_t  req_addr;
    word_t  req_wdata;
    strb_t  req_wstrb;
    word_t  rdata_q;

    //////////////////////////////
    // Lane merge
    //////////////////////////////
    assign any_ce = |lane_ce_i;

    always_comb begin
        sel_we    = 1'b0;
        sel_addr  = '0;
        sel_wdata = '0;
        sel_wstrb = '0;
        // Walk down so the lowest set lane wins
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (lane_ce_i[i]) begin
                sel_we    = lane_we_i[i];
                sel_addr  = lane_addr_i[i];
                sel_wdata = lane_wdata_i[i];
                sel_wstrb = lane_wstrb_i[i];
            end
        end
    end

    //////////////////////////////
    // Request FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (any_ce) state <= S_REQ;
                S_REQ:  if (req_we ? wr_rdy_i : rd_rdy_i) state <= S_WAIT;
                S_WAIT: if (req_we ? wr_done_i : ret_valid_i) state <= S_DONE;
                S_DONE: state <= S_IDLE;           // One cycle of data_ok
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && any_ce) begin
            req_we    <= sel_we;
            req_addr  <= sel_addr;
            req_wdata <= sel_wdata;
            req_wstrb <= sel_wstrb;
        end
        if (state == S_WAIT && !req_we && ret_valid_i) begin
            rdata_q <= ret_data_i;
        end
    end

    assign dcache_ready_o = (state == S_IDLE);
    assign data_ok_o      = (state == S_DONE);
    assign rdata_o        = rdata_q;

    assign rd_req_o  = (state == S_REQ) && !req_we;
    assign rd_addr_o = req_addr;
    assign wr_req_o  = (state == S_REQ) && req_we;
    assign wr_addr_o = req_addr;
    assign wr_data_o = req_wdata;
    assign wr_strb_o = req_wstrb;

endmodule

// ==== axi_read_master.sv ====
module axi_read_master
    import mem_bridge_pkg::*;
#(
    parameter int LINE_BEATS = 4
) (
    input  logic       clk,
    input  logic       reset_i,

    // Instruction refill
    input  logic       icache_rd_req_i,
    input  addr_t      icache_addr_i,
    output logic       icache_rd_rdy_o,
    output logic       icache_ret_valid_o,
    output logic       icache_ret_last_o,
    output word_t      icache_ret_data_o,

    // Data read
    input  logic       data_rd_req_i,
    input  addr_t      data_rd_addr_i,
    output logic       data_rd_rdy_o,
    output logic       data_ret_valid_o,
    output word_t      data_ret_data_o,

    // AR channel
    output axi_id_t    arid_o,
    output addr_t      araddr_o,
    output axi_len_t   arlen_o,
    output axi_size_t  arsize_o,
    output axi_burst_t arburst_o,
    output logic       arvalid_o,
    input  logic       arready_i,

    // R channel
    input  axi_id_t    rid_i,
    input  word_t      rdata_i,
    input  logic       rlast_i,
    input  logic       rvalid_i,
    output logic       rready_o
);

    logic     ar_valid;
    axi_id_t  ar_id;
    addr_t    ar_addr;
    axi_len_t ar_len;
    logic     inst_busy;   // Line refill in flight
    logic     data_busy;   // Data read in flight
    logic     pick_data;
    logic     pick_inst;
    logic     ar_fire;
    logic     r_inst;
    logic     r_data;

    // Data side goes first
    assign pick_data = !ar_valid && data_rd_req_i && !data_busy;
    assign pick_inst = !ar_valid && icache_rd_req_i && !inst_busy && !pick_data;
    assign ar_fire   = ar_valid && arready_i;

    assign r_inst = rvalid_i && (rid_i == INST_ID);
    assign r_data = rvalid_i && (rid_i == DATA_ID);

    //////////////////////////////
    // AR issue
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ar_valid  <= 1'b0;
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (ar_fire) begin
                ar_valid <= 1'b0;
            end else if (pick_data || pick_inst) begin
                ar_valid <= 1'b1;
            end

            if (pick_data) begin
                data_busy <= 1'b1;
            end else if (r_data && rlast_i) begin
                data_busy <= 1'b0;
            end

            if (pick_inst) begin
                inst_busy <= 1'b1;
            end else if (r_inst && rlast_i) begin
                inst_busy <= 1'b0;   // Whole line returned
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pick_data) begin
            ar_id   <= DATA_ID;
            ar_addr <= data_rd_addr_i;
            ar_len  <= '0;
        end else if (pick_inst) begin
            ar_id   <= INST_ID;
            ar_addr <= icache_addr_i;
            ar_len  <= axi_len_t'(LINE_BEATS - 1);
        end
    end

    assign arid_o    = ar_id;
    assign araddr_o  = ar_addr;
    assign arlen_o   = ar_len;
    assign arsize_o  = AXI_SIZE_WORD;
    assign arburst_o = AXI_BURST_INCR;
    assign arvalid_o = ar_valid;

    // Accept strobes on the AR handshake
    assign icache_rd_rdy_o = ar_fire && (ar_id == INST_ID);
    assign data_rd_rdy_o   = ar_fire && (ar_id == DATA_ID);

    //////////////////////////////
    // R routing by id
    //////////////////////////////
    assign rready_o = 1'b1;

    assign icache_ret_valid_o = r_inst;
    assign icache_ret_last_o  = r_inst && rlast_i;
    assign icache_ret_data_o  = rdata_i;
    assign data_ret_valid_o   = r_data;
    assign data_ret_data_o    = rdata_i;

endmodule

// ==== axi_write_master.sv ====
module axi_write_master
    import mem_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,

    // Data write request
    input  logic       wr_req_i,
    input  addr_t      wr_addr_i,
    input  word_t      wr_data_i,
    input  strb_t      wr_strb_i,
    output logic       wr_rdy_o,
    output logic       wr_done_o,

    // AW channel
    output axi_id_t    awid_o,
    output addr_t      awaddr_o,
    output axi_len_t   awlen_o,
    output axi_size_t  awsize_o,
    output axi_burst_t awburst_o,
    output logic       awvalid_o,
    input  logic       awready_i,

    // W channel
    output word_t      wdata_o,
    output strb_t      wstrb_o,
    output logic       wlast_o,
    output logic       wvalid_o,
    input  logic       wready_i,

    // B channel
    input  axi_id_t    bid_i,
    input  logic       bvalid_i,
    output logic       bready_o
);

    logic  aw_valid;
    logic  w_valid;
    logic  b_wait;     // Write issued, response not yet seen
    addr_t aw_addr;
    word_t w_data;
    strb_t w_strb;
    logic  start;
    logic  b_fire;

    assign start  = wr_req_i && !b_wait;
    assign b_fire = bvalid_i && (bid_i == DATA_ID) && b_wait;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_wait   <= 1'b0;
        end else begin
            if (start) begin
                aw_valid <= 1'b1;   // Address and data raised together
                w_valid  <= 1'b1;
                b_wait   <= 1'b1;
            end else begin
                if (aw_valid && awready_i) aw_valid <= 1'b0;
                if (w_valid && wready_i)   w_valid  <= 1'b0;
                if (b_fire)                b_wait   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            aw_addr <= wr_addr_i;
            w_data  <= wr_data_i;
            w_strb  <= wr_strb_i;
        end
    end

    // Both channels finished, whichever handshake came last
    assign wr_rdy_o  = (aw_valid || w_valid) && (!aw_valid || awready_i)
                       && (!w_valid || wready_i);
    assign wr_done_o = b_fire;

    assign awid_o    = DATA_ID;
    assign awaddr_o  = aw_addr;
    assign awlen_o   = '0;          // Single beat
    assign awsize_o  = AXI_SIZE_WORD;
    assign awburst_o = AXI_BURST_INCR;
    assign awvalid_o = aw_valid;

    assign wdata_o  = w_data;
    assign wstrb_o  = w_strb;
    assign wlast_o  = 1'b1;
    assign wvalid_o = w_valid;
    assign bready_o = 1'b1;

endmodule

// ==== mem_bridge_top.sv ====
module mem_bridge_top
    import mem_bridge_pkg::*;
#(
    parameter int LINE_BEATS = 4
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // Instruction refill
    input  logic                  icache_rd_req_i,
    input  addr_t                 icache_addr_i,
    output logic                  icache_rd_rdy_o,
    output logic                  icache_ret_valid_o,
    output logic                  icache_ret_last_o,
    output word_t                 icache_ret_data_o,

    // Execution lanes
    input  logic  [NUM_LANES-1:0] lane_ce_i,
    input  logic  [NUM_LANES-1:0] lane_we_i,
    input  addr_t [NUM_LANES-1:0] lane_addr_i,
    input  word_t [NUM_LANES-1:0] lane_wdata_i,
    input  strb_t [NUM_LANES-1:0] lane_wstrb_i,
    output logic                  dcache_ready_o,
    output logic                  data_ok_o,
    output word_t                 rdata_o,

    // AXI read
    output axi_id_t               arid_o,
    output addr_t                 araddr_o,
    output axi_len_t              arlen_o,
    output axi_size_t             arsize_o,
    output axi_burst_t            arburst_o,
    output logic                  arvalid_o,
    input  logic                  arready_i,
    input  axi_id_t               rid_i,
    input  word_t                 rdata_i,
    input  logic                  rlast_i,
    input  logic                  rvalid_i,
    output logic                  rready_o,

    // AXI write
    output axi_id_t               awid_o,
    output addr_t                 awaddr_o,
    output axi_len_t              awlen_o,
    output axi_size_t             awsize_o,
    output axi_burst_t            awburst_o,
    output logic                  awvalid_o,
    input  logic                  awready_i,
    output word_t                 wdata_o,
    output strb_t                 wstrb_o,
    output logic                  wlast_o,
    output logic                  wvalid_o,
    input  logic                  wready_i,
    input  axi_id_t               bid_i,
    input  logic                  bvalid_i,
    output logic                  bready_o
);

    // Data port <-> read master
    logic  dc_rd_req;
    addr_t dc_rd_addr;
    logic  dc_rd_rdy;
    logic  dc_ret_valid;
    word_t dc_ret_data;

    // Data port <-> write master
    logic  dc_wr_req;
    addr_t dc_wr_addr;
    word_t dc_wr_data;
    strb_t dc_wr_strb;
    logic  dc_wr_rdy;
    logic  dc_wr_done;

    dcache_port u_dcache_port (
        .clk           (clk),
        .reset_i       (reset_i),
        .lane_ce_i     (lane_ce_i),
        .lane_we_i     (lane_we_i),
        .lane_addr_i   (lane_addr_i),
        .lane_wdata_i  (lane_wdata_i),
        .lane_wstrb_i  (lane_wstrb_i),
        .dcache_ready_o(dcache_ready_o),
        .data_ok_o     (data_ok_o),
        .rdata_o       (rdata_o),
        .rd_req_o      (dc_rd_req),
        .rd_addr_o     (dc_rd_addr),
        .rd_rdy_i      (dc_rd_rdy),
        .ret_valid_i   (dc_ret_valid),
        .ret_data_i    (dc_ret_data),
        .wr_req_o      (dc_wr_req),
        .wr_addr_o     (dc_wr_addr),
        .wr_data_o     (dc_wr_data),
        .wr_strb_o     (dc_wr_strb),
        .wr_rdy_i      (dc_wr_rdy),
        .wr_done_i     (dc_wr_done)
    );

    axi_read_master #(
        .LINE_BEATS(LINE_BEATS)
    ) u_axi_read_master (
        .clk               (clk),
        .reset_i           (reset_i),
        .icache_rd_req_i   (icache_rd_req_i),
        .icache_addr_i     (icache_addr_i),
        .icache_rd_rdy_o   (icache_rd_rdy_o),
        .icache_ret_valid_o(icache_ret_valid_o),
        .icache_ret_last_o (icache_ret_last_o),
        .icache_ret_data_o (icache_ret_data_o),
        .data_rd_req_i     (dc_rd_req),
        .data_rd_addr_i    (dc_rd_addr),
        .data_rd_rdy_o     (dc_rd_rdy),
        .data_ret_valid_o  (dc_ret_valid),
        .data_ret_data_o   (dc_ret_data),
        .arid_o            (arid_o),
        .araddr_o          (araddr_o),
        .arlen_o           (arlen_o),
        .arsize_o          (arsize_o),
        .arburst_o         (arburst_o),
        .arvalid_o         (arvalid_o),
        .arready_i         (arready_i),
        .rid_i             (rid_i),
        .rdata_i           (rdata_i),
        .rlast_i           (rlast_i),
        .rvalid_i          (rvalid_i),
        .rready_o          (rready_o)
    );

    axi_write_master u_axi_write_master (
        .clk      (clk),
        .reset_i  (reset_i),
        .wr_req_i (dc_wr_req),
        .wr_addr_i(dc_wr_addr),
        .wr_data_i(dc_wr_data),
        .wr_strb_i(dc_wr_strb),
        .wr_rdy_o (dc_wr_rdy),
        .wr_done_o(dc_wr_done),
        .awid_o   (awid_o),
        .awaddr_o (awaddr_o),
        .awlen_o  (awlen_o),
        .awsize_o (awsize_o),
        .awburst_o(awburst_o),
        .awvalid_o(awvalid_o),
        .awready_i(awready_i),
        .wdata_o  (wdata_o),
        .wstrb_o  (wstrb_o),
        .wlast_o  (wlast_o),
        .wvalid_o (wvalid_o),
        .wready_i (wready_i),
        .bid_i    (bid_i),
        .bvalid_i (bvalid_i),
        .bready_o (bready_o)
    );

endmodule

// ==== tb_axi_mem_model.sv ====
module tb_axi_mem_model
    import mem_bridge_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  axi_id_t  arid_i,
    input  addr_t    araddr_i,
    input  axi_len_t arlen_i,
    input  logic     arvalid_i,
    output logic     arready_o,
    output axi_id_t  rid_o,
    output word_t    rdata_o,
    output logic     rlast_o,
    output logic     rvalid_o,
    input  logic     rready_i,
    input  addr_t    awaddr_i,
    input  logic     awvalid_i,
    output logic     awready_o,
    input  word_t    wdata_i,
    input  strb_t    wstrb_i,
    input  logic     wvalid_i,
    output logic     wready_o,
    output axi_id_t  bid_o,
    output logic     bvalid_o,
    input  logic     bready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t       mem [256];
    logic [32:0] inst_q[$];   // {last, data}
    logic [32:0] data_q[$];
    logic [32:0] beat;
    logic [15:0] lfsr = 16'd47;
    logic [1:0]  ar_wait, r_wait, aw_wait, w_wait, b_wait;
    logic        aw_got, w_got;
    logic [7:0]  aw_idx;
    word_t       w_data;
    strb_t       w_strb;
    logic        use_inst;

    // Galois LFSR, one step per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 16'hB400;
            r[i] = b;
        end
        return r;
    endfunction

    initial begin
        for (int k = 0; k < 256; k++) mem[k] = (word_t'(k) * 32'h01010101) ^ 32'hA5A5A5A5;
    end

    assign bid_o = DATA_ID;

    always @(posedge clk) begin
        if (reset_i) begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            rvalid_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            rlast_o   <= 1'b0;
            rdata_o   <= '0;
            rid_o     <= '0;
            {ar_wait, r_wait, aw_wait, w_wait, b_wait} <= '0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            inst_q.delete();
            data_q.delete();
        end else begin
            ///////////////////////////////
            // AR and R
            ///////////////////////////////
            if (arvalid_i && arready_o) begin
                for (int i = 0; i <= int'(arlen_i); i++) begin
                    beat = {i == int'(arlen_i), mem[8'(int'(araddr_i[9:2]) + i)]};
                    if (arid_i == INST_ID) inst_q.push_back(beat);
                    else if (arid_i == DATA_ID) data_q.push_back(beat);
                end
                arready_o <= 1'b0;
                ar_wait   <= 2'(rand_bits(2));
            end else if (arvalid_i) begin
                if (ar_wait == 0) arready_o <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end

            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end else if (!rvalid_o) begin
                if (r_wait != 0) begin
                    r_wait <= r_wait - 1;
                end else if (inst_q.size() > 0 || data_q.size() > 0) begin
                    // Random pick between ids when both have beats
                    use_inst = inst_q.size() > 0 && (data_q.size() == 0 || rand_bits(1) == 1);
                    beat     = use_inst ? inst_q.pop_front() : data_q.pop_front();
                    rid_o    <= use_inst ? INST_ID : DATA_ID;
                    rdata_o  <= beat[31:0];
                    rlast_o  <= beat[32];
                    rvalid_o <= 1'b1;
                    r_wait   <= 2'(rand_bits(2));
                end
            end

            ///////////////////////////////
            // AW, W and B
            ///////////////////////////////
            if (awvalid_i && awready_o) begin
                aw_idx    <= awaddr_i[9:2];
                aw_got    <= 1'b1;
                awready_o <= 1'b0;
                aw_wait   <= 2'(rand_bits(2));
            end else if (awvalid_i) begin
                if (aw_wait == 0) awready_o <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end

            if (wvalid_i && wready_o) begin
                w_data   <= wdata_i;
                w_strb   <= wstrb_i;
                w_got    <= 1'b1;
                wready_o <= 1'b0;
                w_wait   <= 2'(rand_bits(2));
            end else if (wvalid_i) begin
                if (w_wait == 0) wready_o <= 1'b1;
                else w_wait <= w_wait - 1;
            end

            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end else if (!bvalid_o && aw_got && w_got) begin
                if (b_wait == 0) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[b]) mem[aw_idx][8*b +: 8] = w_data[8*b +: 8];
                    end
                    bvalid_o <= 1'b1;
                    aw_got   <= 1'b0;
                    w_got    <= 1'b0;
                    b_wait   <= 2'(rand_bits(2));
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
        end
    end

endmodule

// ==== tb_mem_bridge.sv ====
module tb_mem_bridge
    import mem_bridge_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_BEATS = 4;

    logic clk;
    logic reset_i;
    logic icache_rd_req_i;
    addr_t icache_addr_i;
    logic icache_rd_rdy_o, icache_ret_valid_o, icache_ret_last_o;
    word_t icache_ret_data_o;
    logic  [NUM_LANES-1:0] lane_ce_i, lane_we_i;
    addr_t [NUM_LANES-1:0] lane_addr_i;
    word_t [NUM_LANES-1:0] lane_wdata_i;
    strb_t [NUM_LANES-1:0] lane_wstrb_i;
    logic dcache_ready_o, data_ok_o;
    word_t rdata_o;
    axi_id_t arid, rid, awid, bid;
    addr_t araddr, awaddr;
    axi_len_t arlen, awlen;
    axi_size_t arsize, awsize;
    axi_burst_t arburst, awburst;
    logic arvalid, arready, rlast, rvalid, rready;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    word_t rdata, wdata;
    strb_t wstrb;

    word_t       shadow [256];   // Reference copy of memory
    word_t       inst_beats[$];
    logic        inst_lasts[$];
    word_t       data_result;
    logic [15:0] lfsr = 16'd47;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;

    mem_bridge_top #(.LINE_BEATS(LINE_BEATS)) dut (
        .clk(clk), .reset_i(reset_i),
        .icache_rd_req_i(icache_rd_req_i), .icache_addr_i(icache_addr_i),
        .icache_rd_rdy_o(icache_rd_rdy_o), .icache_ret_valid_o(icache_ret_valid_o),
        .icache_ret_last_o(icache_ret_last_o), .icache_ret_data_o(icache_ret_data_o),
        .lane_ce_i(lane_ce_i), .lane_we_i(lane_we_i), .lane_addr_i(lane_addr_i),
        .lane_wdata_i(lane_wdata_i), .lane_wstrb_i(lane_wstrb_i),
        .dcache_ready_o(dcache_ready_o), .data_ok_o(data_ok_o), .rdata_o(rdata_o),
        .arid_o(arid), .araddr_o(araddr), .arlen_o(arlen), .arsize_o(arsize),
        .arburst_o(arburst), .arvalid_o(arvalid), .arready_i(arready),
        .rid_i(rid), .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
        .awid_o(awid), .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize),
        .awburst_o(awburst), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .wvalid_o(wvalid),
        .wready_i(wready), .bid_i(bid), .bvalid_i(bvalid), .bready_o(bready)
    );

    tb_axi_mem_model u_mem (
        .clk(clk), .reset_i(reset_i),
        .arid_i(arid), .araddr_i(araddr), .arlen_i(arlen), .arvalid_i(arvalid),
        .arready_o(arready), .rid_o(rid), .rdata_o(rdata), .rlast_o(rlast),
        .rvalid_o(rvalid), .rready_i(rready), .awaddr_i(awaddr), .awvalid_i(awvalid),
        .awready_o(awready), .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid),
        .wready_o(wready), .bid_o(bid), .bvalid_o(bvalid), .bready_i(bready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 16'hB400;
            r[i] = b;
        end
        return r;
    endfunction

    // Old word with only the strobed bytes replaced
    function word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t st);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %08h actual %08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input axi_len_t exp, input axi_len_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_size(input string name, input axi_size_t exp, input axi_size_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_burst(input string name, input axi_burst_t exp,
                               input axi_burst_t act);
        if (exp !== act) begin
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed", name);
        end
    endtask

    ///////////////////////////////
    // AXI fields checked at each handshake
    ///////////////////////////////
    always @(negedge clk) begin
        if (!reset_i && arvalid && arready) begin
            // Line refill is a full burst, data read a single beat
            check_len("arlen", (arid == axi_id_t'(0)) ? axi_len_t'(LINE_BEATS - 1)
                                                     : axi_len_t'(0), arlen);
            check_size("arsize", axi_size_t'(2), arsize);
            check_burst("arburst", axi_burst_t'(1), arburst);
        end
        if (!reset_i && awvalid && awready) begin
            check_id("awid", axi_id_t'(1), awid);
            check_len("awlen", axi_len_t'(0), awlen);
            check_size("awsize", axi_size_t'(2), awsize);
            check_burst("awburst", axi_burst_t'(1), awburst);
        end
        if (!reset_i && wvalid && wready) begin
            check_bit("wlast", 1'b1, wlast);   // Single beat is always last
        end
    end

    ///////////////////////////////
    // Request driver, called on a rising edge
    ///////////////////////////////
    task automatic run_ops(input string name, input bit do_inst, input addr_t iaddr,
                           input bit do_dat, input int lane, input logic we,
                           input addr_t daddr, input word_t wd, input strb_t st);
        bit inst_acc, inst_done, dat_acc, dat_done;
        int cyc;
        inst_beats.delete();
        inst_lasts.delete();
        inst_acc  = 0;
        dat_acc   = 0;
        inst_done = !do_inst;
        dat_done  = !do_dat;
        if (do_inst) begin
            icache_rd_req_i <= 1'b1;
            icache_addr_i   <= iaddr;
        end
        if (do_dat) begin
            lane_ce_i[lane]    <= 1'b1;
            lane_we_i[lane]    <= we;
            lane_addr_i[lane]  <= daddr;
            lane_wdata_i[lane] <= wd;
            lane_wstrb_i[lane] <= st;
        end
        cyc = 0;
        while (!(inst_done && dat_done) && cyc < 200) begin
            @(negedge clk);
            if (do_inst && icache_rd_rdy_o) inst_acc = 1;
            if (do_inst && icache_ret_valid_o) begin
                inst_beats.push_back(icache_ret_data_o);
                inst_lasts.push_back(icache_ret_last_o);
                if (icache_ret_last_o) inst_done = 1;
            end
            if (do_dat && !dcache_ready_o) dat_acc = 1;
            if (do_dat && data_ok_o) begin
                data_result = rdata_o;
                dat_done    = 1;
            end
            @(posedge clk);
            if (inst_acc) icache_rd_req_i <= 1'b0;
            if (dat_acc) lane_ce_i[lane] <= 1'b0;
            cyc++;
        end
        if (!(inst_done && dat_done)) begin
            $display("timeout: %s did not complete within 200 cycles", name);
            errors++;
        end
        if (do_inst && !inst_acc) begin
            $display("%s: the refill request was never accepted", name);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input int base);
        check_word({name, " beat count"}, word_t'(LINE_BEATS), word_t'(inst_beats.size()));
        for (int i = 0; i < inst_beats.size() && i < LINE_BEATS; i++) begin
            check_word($sformatf("%s beat %0d", name, i), shadow[(base + i) % 256],
                       inst_beats[i]);
            check_bit($sformatf("%s last %0d", name, i), i == LINE_BEATS - 1, inst_lasts[i]);
        end
    endtask

    initial begin
        int    e, base, idx, idx2;
        word_t wd;
        strb_t st;
        string nm;
        for (int k = 0; k < 256; k++) shadow[k] = (word_t'(k) * 32'h01010101) ^ 32'hA5A5A5A5;
        reset_i = 1'b1;
        icache_rd_req_i = 1'b0;
        icache_addr_i = '0;
        lane_ce_i = '0;
        lane_we_i = '0;
        lane_addr_i = '0;
        lane_wdata_i = '0;
        lane_wstrb_i = '0;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        e = errors;   // Idle outputs right after reset
        repeat (5) begin
            @(negedge clk);
            check_bit("reset dcache_ready_o", 1'b1, dcache_ready_o);
            check_bit("reset data_ok_o", 1'b0, data_ok_o);
            check_bit("reset icache_ret_valid_o", 1'b0, icache_ret_valid_o);
        end
        finish_test("reset_state", e);
        @(posedge clk);

        for (int r = 0; r < 4; r++) begin
            e    = errors;
            nm   = $sformatf("refill_%0d", r);
            base = int'(rand_bits(8)) & ~(LINE_BEATS - 1);
            run_ops(nm, 1, addr_t'(base << 2), 0, 0, 1'b0, '0, '0, '0);
            check_line(nm, base);
            finish_test(nm, e);

            e   = errors;
            nm  = $sformatf("data_read_%0d", r);
            idx = int'(rand_bits(8));
            run_ops(nm, 0, '0, 1, 0, 1'b0, addr_t'(idx << 2), '0, '0);
            check_word(nm, shadow[idx], data_result);
            finish_test(nm, e);

            e   = errors;
            nm  = $sformatf("data_write_%0d", r);
            idx = int'(rand_bits(8));
            wd  = rand_bits(32);
            st  = 4'(rand_bits(4));
            run_ops(nm, 0, '0, 1, 1, 1'b1, addr_t'(idx << 2), wd, st);
            shadow[idx] = merge_bytes(shadow[idx], wd, st);
            run_ops(nm, 0, '0, 1, 0, 1'b0, addr_t'(idx << 2), '0, '0);
            check_word(nm, shadow[idx], data_result);
            finish_test(nm, e);
        end

        // Both lanes raised on the same edge
        e    = errors;
        idx  = int'(rand_bits(8));
        idx2 = (idx + 1) % 256;
        lane_ce_i[1]   <= 1'b1;
        lane_we_i[1]   <= 1'b0;
        lane_addr_i[1] <= addr_t'(idx2 << 2);
        run_ops("priority lane 0", 0, '0, 1, 0, 1'b0, addr_t'(idx << 2), '0, '0);
        check_word("priority lane 0", shadow[idx], data_result);
        run_ops("priority lane 1", 0, '0, 1, 1, 1'b0, addr_t'(idx2 << 2), '0, '0);
        check_word("priority lane 1", shadow[idx2], data_result);
        finish_test("lane_priority", e);

        e    = errors;
        base = int'(rand_bits(8)) & ~(LINE_BEATS - 1);
        idx  = int'(rand_bits(8));
        run_ops("overlap", 1, addr_t'(base << 2), 1, 0, 1'b0, addr_t'(idx << 2), '0, '0);
        check_line("overlap", base);
        check_word("overlap data", shadow[idx], data_result);
        finish_test("overlap", e);

        $display("tests passed: %0d failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== list.f ====
mem_bridge_pkg.sv
dcache_port.sv
axi_read_master.sv
axi_write_master.sv
mem_bridge_top.sv
tb_axi_mem_model.sv
tb_mem_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_mem_bridge -f list.f

./obj_dir/Vtb_mem_bridge | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    exit 0
else
    exit 1
fi
